// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;     // data word, register value or address
    typedef logic [31:0] instr_t;    // raw instruction word
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  mem_size_t;
    typedef logic [1:0]  wb_sel_t;
    typedef logic [2:0]  imm_kind_t;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_R3    = 7'b0110011;
    localparam logic [6:0] OP_LD    = 7'b0000011;
    localparam logic [6:0] OP_ST    = 7'b0100011;
    localparam logic [6:0] OP_BR    = 7'b1100011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // stores share the low three codes
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;   // lui

    localparam mem_size_t SIZE_B = 2'd0;
    localparam mem_size_t SIZE_H = 2'd1;
    localparam mem_size_t SIZE_W = 2'd2;

    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;

    localparam imm_kind_t IMM_I = 3'd0;
    localparam imm_kind_t IMM_S = 3'd1;
    localparam imm_kind_t IMM_B = 3'd2;
    localparam imm_kind_t IMM_U = 3'd3;
    localparam imm_kind_t IMM_J = 3'd4;

endpackage

`default_nettype wire

// File: decode/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  logic [6:0]         opcode,
    input  logic [2:0]         funct3,
    input  logic [6:0]         funct7,
    output logic               rf_write_enable,
    output logic               pc_rs1_sel,       // 1 selects pc as operand a
    output logic               imm_rs2_sel,      // 1 selects imm as operand b
    output rv_pkg::imm_kind_t  imm_kind,
    output rv_pkg::alu_op_t    alu_op,
    output logic               branch,
    output logic               jump,
    output logic               mem_write_enable,
    output logic               mem_read,
    output rv_pkg::mem_size_t  mem_size,
    output logic               load_unsigned,
    output rv_pkg::wb_sel_t    wb_sel,
    output logic               illegal
);

    // alt picks sub or sra
    function automatic rv_pkg::alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    function automatic rv_pkg::mem_size_t size_from_funct3(input logic [2:0] f3);
        case (f3)
            rv_pkg::F3_LB, rv_pkg::F3_LBU: return rv_pkg::SIZE_B;
            rv_pkg::F3_LH, rv_pkg::F3_LHU: return rv_pkg::SIZE_H;
            default:                       return rv_pkg::SIZE_W;
        endcase
    endfunction

    always_comb begin
        rf_write_enable  = 1'b0;
        pc_rs1_sel       = 1'b0;
        imm_rs2_sel      = 1'b0;
        imm_kind         = rv_pkg::IMM_I;
        alu_op           = rv_pkg::ALU_ADD;
        branch           = 1'b0;
        jump             = 1'b0;
        mem_write_enable = 1'b0;
        mem_read         = 1'b0;
        mem_size         = rv_pkg::SIZE_W;
        load_unsigned    = 1'b0;
        wb_sel           = rv_pkg::WB_ALU;
        illegal          = 1'b0;

        case (opcode)
            rv_pkg::OP_IMM: begin
                rf_write_enable = 1'b1;
                imm_rs2_sel     = 1'b1;
                // addi has no subtract form, only srai looks at funct7
                alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
            end
            rv_pkg::OP_R3: begin
                rf_write_enable = 1'b1;
                alu_op          = alu_from_funct3(funct3, funct7[5]);
            end
            rv_pkg::OP_LD: begin
                rf_write_enable = 1'b1;
                imm_rs2_sel     = 1'b1;
                mem_read        = 1'b1;
                mem_size        = size_from_funct3(funct3);
                load_unsigned   = funct3 == rv_pkg::F3_LBU || funct3 == rv_pkg::F3_LHU;
                wb_sel          = rv_pkg::WB_MEM;
            end
            rv_pkg::OP_ST: begin
                imm_rs2_sel      = 1'b1;
                imm_kind         = rv_pkg::IMM_S;
                mem_write_enable = 1'b1;
                mem_size         = size_from_funct3(funct3);
            end
            rv_pkg::OP_BR: begin
                pc_rs1_sel  = 1'b1;     // target base is pc
                imm_rs2_sel = 1'b1;
                imm_kind    = rv_pkg::IMM_B;
                branch      = 1'b1;
            end
            rv_pkg::OP_LUI: begin
                rf_write_enable = 1'b1;
                imm_rs2_sel     = 1'b1;
                imm_kind        = rv_pkg::IMM_U;
                alu_op          = rv_pkg::ALU_PASS_B;
            end
            rv_pkg::OP_AUIPC: begin
                rf_write_enable = 1'b1;
                pc_rs1_sel      = 1'b1;
                imm_rs2_sel     = 1'b1;
                imm_kind        = rv_pkg::IMM_U;
            end
            rv_pkg::OP_JAL: begin
                rf_write_enable = 1'b1;
                pc_rs1_sel      = 1'b1;
                imm_rs2_sel     = 1'b1;
                imm_kind        = rv_pkg::IMM_J;
                jump            = 1'b1;
                wb_sel          = rv_pkg::WB_PC4;
            end
            rv_pkg::OP_JALR: begin
                rf_write_enable = 1'b1;
                imm_rs2_sel     = 1'b1;   // base is rs1
                jump            = 1'b1;
                wb_sel          = rv_pkg::WB_PC4;
            end
            default: illegal = 1'b1;      // runs as a no-op
        endcase
    end

endmodule

`default_nettype wire

// File: decode/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
    input  rv_pkg::instr_t    instr,
    input  rv_pkg::imm_kind_t imm_kind,
    output rv_pkg::word_t     imm
);

    logic sign;

    assign sign = instr[31];   // every format keeps its sign here

    always_comb begin
        case (imm_kind)
            rv_pkg::IMM_I: imm = {{20{sign}}, instr[31:20]};
            rv_pkg::IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            rv_pkg::IMM_B: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv_pkg::IMM_U: imm = {instr[31:12], 12'b0};
            rv_pkg::IMM_J: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default:       imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  logic             write_enable,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    write_data,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);

    rv_pkg::word_t regs [1:31];   // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd != '0) begin
            regs[rd] <= write_data;
        end
    end

    // write-through so a reader in the write cycle sees the new value
    assign rs1_data = (rs1 == '0) ? '0 :
                      (write_enable && rd == rs1) ? write_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (write_enable && rd == rs2) ? write_data : regs[rs2];

endmodule

`default_nettype wire

// File: execute/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  rv_pkg::word_t     pc,
    input  rv_pkg::reg_idx_t  rd,
    input  logic [2:0]        funct3,         // branch condition
    input  logic              rf_write_enable,
    input  logic              pc_rs1_sel,
    input  logic              imm_rs2_sel,
    input  rv_pkg::alu_op_t   alu_op,
    input  logic              branch,
    input  logic              jump,
    input  logic              mem_write_enable,
    input  logic              mem_read,
    input  rv_pkg::mem_size_t mem_size,
    input  logic              load_unsigned,
    input  rv_pkg::wb_sel_t   wb_sel,
    input  logic              illegal,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     imm,
    output logic              ex_valid,
    output rv_pkg::word_t     ex_result,
    output rv_pkg::word_t     ex_store_data,
    output rv_pkg::reg_idx_t  ex_rd,
    output rv_pkg::word_t     ex_pc_plus4,
    output logic              ex_mem_write,
    output logic              ex_mem_read,
    output rv_pkg::mem_size_t ex_mem_size,
    output logic              ex_load_unsigned,
    output rv_pkg::wb_sel_t   ex_wb_sel,
    output logic              ex_rf_write,
    output logic              ex_illegal,
    output logic              redirect,
    output rv_pkg::word_t     redirect_pc
);

    rv_pkg::word_t   op_a;
    rv_pkg::word_t   op_b;
    rv_pkg::word_t   target_sum;
    logic            taken;
    logic            writes_rd;
    rv_pkg::word_t   op_a_q;
    rv_pkg::word_t   op_b_q;
    rv_pkg::alu_op_t alu_op_q;

    assign op_a       = pc_rs1_sel ? pc : rs1_data;
    assign op_b       = imm_rs2_sel ? imm : rs2_data;
    assign target_sum = op_a + imm;   // pc+imm, or rs1+imm for jalr
    assign writes_rd  = rf_write_enable && !illegal;

    // branch compare runs before issue so redirect lands one edge later
    always_comb begin
        case (funct3)
            rv_pkg::F3_BEQ:  taken = rs1_data == rs2_data;
            rv_pkg::F3_BNE:  taken = rs1_data != rs2_data;
            rv_pkg::F3_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
            rv_pkg::F3_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
            rv_pkg::F3_BLTU: taken = rs1_data < rs2_data;
            rv_pkg::F3_BGEU: taken = rs1_data >= rs2_data;
            default:         taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_rf_write  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_illegal   <= 1'b0;
            redirect     <= 1'b0;
        end else begin
            ex_valid     <= instr_valid;
            ex_rf_write  <= instr_valid && writes_rd;
            ex_mem_write <= instr_valid && mem_write_enable && !illegal;
            ex_mem_read  <= instr_valid && mem_read && !illegal;
            ex_illegal   <= instr_valid && illegal;
            redirect     <= instr_valid && !illegal && (jump || (branch && taken));
        end
    end

    always_ff @(posedge clk) begin
        op_a_q           <= op_a;
        op_b_q           <= op_b;
        alu_op_q         <= alu_op;
        ex_store_data    <= rs2_data;
        ex_rd            <= writes_rd ? rd : '0;   // stores, branches keep x0
        ex_pc_plus4      <= pc + 32'd4;
        ex_mem_size      <= mem_size;
        ex_load_unsigned <= load_unsigned;
        ex_wb_sel        <= wb_sel;
        redirect_pc      <= (jump && !pc_rs1_sel) ? {target_sum[31:1], 1'b0} : target_sum;
    end

    always_comb begin
        case (alu_op_q)
            rv_pkg::ALU_SUB:    ex_result = op_a_q - op_b_q;
            rv_pkg::ALU_SLL:    ex_result = op_a_q << op_b_q[4:0];
            rv_pkg::ALU_SLT:    ex_result = {31'b0, $signed(op_a_q) < $signed(op_b_q)};
            rv_pkg::ALU_SLTU:   ex_result = {31'b0, op_a_q < op_b_q};
            rv_pkg::ALU_XOR:    ex_result = op_a_q ^ op_b_q;
            rv_pkg::ALU_SRL:    ex_result = op_a_q >> op_b_q[4:0];
            rv_pkg::ALU_SRA:    ex_result = $signed(op_a_q) >>> op_b_q[4:0];
            rv_pkg::ALU_OR:     ex_result = op_a_q | op_b_q;
            rv_pkg::ALU_AND:    ex_result = op_a_q & op_b_q;
            rv_pkg::ALU_PASS_B: ex_result = op_b_q;
            default:            ex_result = op_a_q + op_b_q;
        endcase
    end

endmodule

`default_nettype wire

// File: result/load_store_unit.sv
`timescale 1ns/100ps
`default_nettype none

module load_store_unit #(
    parameter int DMEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  rv_pkg::word_t     ex_result,       // address for loads and stores
    input  rv_pkg::word_t     ex_store_data,
    input  rv_pkg::reg_idx_t  ex_rd,
    input  rv_pkg::word_t     ex_pc_plus4,
    input  logic              ex_mem_write,
    input  logic              ex_mem_read,
    input  rv_pkg::mem_size_t ex_mem_size,
    input  logic              ex_load_unsigned,
    input  rv_pkg::wb_sel_t   ex_wb_sel,
    input  logic              ex_rf_write,
    input  logic              ex_illegal,
    output logic              wb_valid,
    output rv_pkg::reg_idx_t  wb_rd,
    output rv_pkg::word_t     wb_data,
    output logic              wb_illegal,
    output logic              rf_write
);

    localparam int AW = $clog2(DMEM_WORDS);

    rv_pkg::word_t dmem [DMEM_WORDS];
    logic [AW-1:0] word_addr;
    logic [1:0]    lane;
    logic [3:0]    byte_en;
    rv_pkg::word_t store_word;
    rv_pkg::word_t read_word;
    logic [7:0]    read_byte;
    logic [15:0]   read_half;
    rv_pkg::word_t load_data;
    rv_pkg::word_t wb_next;

    assign word_addr = ex_result[AW+1:2];
    assign lane      = ex_result[1:0];

    always_comb begin
        case (ex_mem_size)
            rv_pkg::SIZE_B: begin
                byte_en    = 4'b0001 << lane;
                store_word = {4{ex_store_data[7:0]}};   // copied to every lane
            end
            rv_pkg::SIZE_H: begin
                byte_en    = lane[1] ? 4'b1100 : 4'b0011;
                store_word = {2{ex_store_data[15:0]}};
            end
            default: begin
                byte_en    = 4'b1111;
                store_word = ex_store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ex_mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) dmem[word_addr][8*i +: 8] <= store_word[8*i +: 8];
            end
        end
    end

    assign read_word = dmem[word_addr];
    assign read_byte = read_word[8*lane +: 8];
    assign read_half = lane[1] ? read_word[31:16] : read_word[15:0];

    always_comb begin
        if (!ex_mem_read) begin
            load_data = '0;
        end else if (ex_mem_size == rv_pkg::SIZE_B) begin
            load_data = {{24{read_byte[7] & ~ex_load_unsigned}}, read_byte};
        end else if (ex_mem_size == rv_pkg::SIZE_H) begin
            load_data = {{16{read_half[15] & ~ex_load_unsigned}}, read_half};
        end else begin
            load_data = read_word;
        end
    end

    always_comb begin
        case (ex_wb_sel)
            rv_pkg::WB_MEM: wb_next = load_data;
            rv_pkg::WB_PC4: wb_next = ex_pc_plus4;   // jal and jalr link
            default:        wb_next = ex_result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid   <= 1'b0;
            wb_illegal <= 1'b0;
            rf_write   <= 1'b0;
        end else begin
            wb_valid   <= ex_valid;
            wb_illegal <= ex_illegal;
            rf_write   <= ex_rf_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= wb_next;
    end

endmodule

`default_nettype wire

// File: hdl/rv_exec_slice.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_slice #(
    parameter int DMEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             instr_valid,
    input  rv_pkg::instr_t   instr,
    input  rv_pkg::word_t    pc,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data,
    output logic             wb_illegal,
    output logic             redirect,
    output rv_pkg::word_t    redirect_pc
);

    logic              rf_write_enable;
    logic              pc_rs1_sel;
    logic              imm_rs2_sel;
    rv_pkg::imm_kind_t imm_kind;
    rv_pkg::alu_op_t   alu_op;
    logic              branch;
    logic              jump;
    logic              mem_write_enable;
    logic              mem_read;
    rv_pkg::mem_size_t mem_size;
    logic              load_unsigned;
    rv_pkg::wb_sel_t   wb_sel;
    logic              illegal;
    rv_pkg::word_t     imm;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;

    logic              ex_valid;
    rv_pkg::word_t     ex_result;
    rv_pkg::word_t     ex_store_data;
    rv_pkg::reg_idx_t  ex_rd;
    rv_pkg::word_t     ex_pc_plus4;
    logic              ex_mem_write;
    logic              ex_mem_read;
    rv_pkg::mem_size_t ex_mem_size;
    logic              ex_load_unsigned;
    rv_pkg::wb_sel_t   ex_wb_sel;
    logic              ex_rf_write;
    logic              ex_illegal;
    logic              rf_write;   // write enable at the end of the pipe

    control_unit u_control (
        .opcode(instr[6:0]), .funct3(instr[14:12]), .funct7(instr[31:25]),
        .rf_write_enable, .pc_rs1_sel, .imm_rs2_sel, .imm_kind, .alu_op,
        .branch, .jump, .mem_write_enable, .mem_read, .mem_size,
        .load_unsigned, .wb_sel, .illegal
    );

    imm_gen u_imm (.instr, .imm_kind, .imm);

    reg_file u_regs (
        .clk, .rst_n, .rs1(instr[19:15]), .rs2(instr[24:20]),
        .write_enable(rf_write), .rd(wb_rd), .write_data(wb_data),
        .rs1_data, .rs2_data
    );

    exec_unit u_exec (
        .clk, .rst_n, .instr_valid, .pc, .rd(instr[11:7]), .funct3(instr[14:12]),
        .rf_write_enable, .pc_rs1_sel, .imm_rs2_sel, .alu_op, .branch, .jump,
        .mem_write_enable, .mem_read, .mem_size, .load_unsigned, .wb_sel,
        .illegal, .rs1_data, .rs2_data, .imm,
        .ex_valid, .ex_result, .ex_store_data, .ex_rd, .ex_pc_plus4,
        .ex_mem_write, .ex_mem_read, .ex_mem_size, .ex_load_unsigned,
        .ex_wb_sel, .ex_rf_write, .ex_illegal, .redirect, .redirect_pc
    );

    load_store_unit #(.DMEM_WORDS(DMEM_WORDS)) u_lsu (
        .clk, .rst_n, .ex_valid, .ex_result, .ex_store_data, .ex_rd,
        .ex_pc_plus4, .ex_mem_write, .ex_mem_read, .ex_mem_size,
        .ex_load_unsigned, .ex_wb_sel, .ex_rf_write, .ex_illegal,
        .wb_valid, .wb_rd, .wb_data, .wb_illegal, .rf_write
    );

endmodule

`default_nettype wire

// File: verif/tb_rv_exec_slice.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_exec_slice;

    localparam int FIELDS    = 9;     // words per pattern line
    localparam int MAX_LINES = 64;

    // column positions inside one pattern line
    localparam int COL_VALID    = 0;
    localparam int COL_INSTR    = 1;
    localparam int COL_PC       = 2;
    localparam int COL_WB_VALID = 3;
    localparam int COL_WB_RD    = 4;
    localparam int COL_WB_DATA  = 5;
    localparam int COL_WB_ILL   = 6;
    localparam int COL_REDIR    = 7;
    localparam int COL_REDIR_PC = 8;

    logic             clk;
    logic             rst_n;
    logic             instr_valid;
    rv_pkg::instr_t   instr;
    rv_pkg::word_t    pc;
    logic             wb_valid;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::word_t    wb_data;
    logic             wb_illegal;
    logic             redirect;
    rv_pkg::word_t    redirect_pc;

    logic [31:0] pat [MAX_LINES*FIELDS];
    int          num_lines;
    int          error_count;
    int          check_count;
    int          cycles;

    rv_exec_slice #(.DMEM_WORDS(256)) uut (
        .clk, .rst_n, .instr_valid, .instr, .pc,
        .wb_valid, .wb_rd, .wb_data, .wb_illegal, .redirect, .redirect_pc
    );

    always #4 clk = ~clk;

    // run length is the pattern count plus reset and pipe drain
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (num_lines > 0 && cycles > num_lines + 20) begin
            $display("timeout: the run did not finish within %0d cycles", num_lines + 20);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_value(input string what, input int line,
                               input logic [31:0] got, input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("** Error at %0t: line %0d %s is %h, expected %h",
                     $time, line, what, got, expected);
        end
    endtask

    // write-back of a line, two edges after it was sampled
    task automatic check_writeback(input int line);
        int base;
        base = line * FIELDS;
        check_value("wb_valid", line, {31'b0, wb_valid}, pat[base + COL_WB_VALID]);
        if (pat[base + COL_WB_VALID] != 0) begin
            check_value("wb_rd", line, {27'b0, wb_rd}, pat[base + COL_WB_RD]);
            check_value("wb_illegal", line, {31'b0, wb_illegal}, pat[base + COL_WB_ILL]);
            if (pat[base + COL_WB_RD] != 0) begin   // data means nothing for rd x0
                check_value("wb_data", line, wb_data, pat[base + COL_WB_DATA]);
            end
        end
    endtask

    task automatic check_redirect(input int line);
        int base;
        base = line * FIELDS;
        check_value("redirect", line, {31'b0, redirect}, pat[base + COL_REDIR]);
        if (pat[base + COL_REDIR] != 0) begin
            check_value("redirect_pc", line, redirect_pc, pat[base + COL_REDIR_PC]);
        end
    endtask

    initial begin
        int n;
        int step;
        int base;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        error_count = 0;
        check_count = 0;
        cycles      = 0;
        num_lines   = 0;

        for (n = 0; n < MAX_LINES * FIELDS; n++) begin
            pat[n] = 32'hffff_ffff;   // marks the end of the file
        end
        $readmemh("verif/exec_patterns.mem", pat);
        while (num_lines < MAX_LINES && pat[num_lines * FIELDS] != 32'hffff_ffff) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            error_count++;
            $display("no stimulus lines could be read from verif/exec_patterns.mem");
        end

        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        for (step = 0; step < num_lines + 2; step++) begin
            @(posedge clk);
            #1;
            if (step >= 1 && step - 1 < num_lines) check_redirect(step - 1);
            if (step >= 2) check_writeback(step - 2);
            if (step < num_lines) begin
                base        = step * FIELDS;
                instr_valid = pat[base + COL_VALID][0];
                instr       = pat[base + COL_INSTR];
                pc          = pat[base + COL_PC];
            end else begin
                instr_valid = 1'b0;   // drain the pipe
                instr       = '0;
                pc          = '0;
            end
        end

        $display("lines: %0d, checks: %0d, errors: %0d", num_lines, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/exec_patterns.mem
// valid instr pc, then expected wb_valid wb_rd wb_data wb_illegal, redirect redirect_pc
// expected columns belong to the instruction on the same line, wb_data unused when wb_rd is 0
1 12300093 00000100 1 01 00000123 0 0 00000000 // addi x1, x0, 0x123
1 ffb00113 00000104 1 02 fffffffb 0 0 00000000 // addi x2, x0, -5
1 800001b7 00000108 1 03 80000000 0 0 00000000 // lui x3, 0x80000
1 00700213 0000010c 1 04 00000007 0 0 00000000 // addi x4, x0, 7
1 00112293 00000110 1 05 00000001 0 0 00000000 // slti x5, x2, 1
1 00113313 00000114 1 06 00000000 0 0 00000000 // sltiu x6, x2, 1
1 0ff0c393 00000118 1 07 000001dc 0 0 00000000 // xori x7, x1, 0xff
1 7000e413 0000011c 1 08 00000723 0 0 00000000 // ori x8, x1, 0x700
1 0f017493 00000120 1 09 000000f0 0 0 00000000 // andi x9, x2, 0xf0
1 00409513 00000124 1 0a 00001230 0 0 00000000 // slli x10, x1, 4
1 00415593 00000128 1 0b 0fffffff 0 0 00000000 // srli x11, x2, 4
1 4081d613 0000012c 1 0c ff800000 0 0 00000000 // srai x12, x3, 8
1 002086b3 00000130 1 0d 0000011e 0 0 00000000 // add x13, x1, x2
1 40208733 00000134 1 0e 00000128 0 0 00000000 // sub x14, x1, x2
1 004097b3 00000138 1 0f 00009180 0 0 00000000 // sll x15, x1, x4
1 00112833 0000013c 1 10 00000001 0 0 00000000 // slt x16, x2, x1
1 001138b3 00000140 1 11 00000000 0 0 00000000 // sltu x17, x2, x1
1 0020c933 00000144 1 12 fffffed8 0 0 00000000 // xor x18, x1, x2
1 0041d9b3 00000148 1 13 01000000 0 0 00000000 // srl x19, x3, x4
1 4041da33 0000014c 1 14 ff000000 0 0 00000000 // sra x20, x3, x4
1 0040eab3 00000150 1 15 00000127 0 0 00000000 // or x21, x1, x4
1 00117b33 00000154 1 16 00000123 0 0 00000000 // and x22, x2, x1
1 00508013 00000158 1 00 00000000 0 0 00000000 // addi x0, x1, 5
1 05202023 0000015c 1 00 00000000 0 0 00000000 // sw x18, 0x40(x0)
1 041000a3 00000160 1 00 00000000 0 0 00000000 // sb x1, 0x41(x0)
1 04f01123 00000164 1 00 00000000 0 0 00000000 // sh x15, 0x42(x0)
1 04002c03 00000168 1 18 918023d8 0 0 00000000 // lw x24, 0x40(x0)
1 04100c83 0000016c 1 19 00000023 0 0 00000000 // lb x25, 0x41(x0)
1 04000d03 00000170 1 1a ffffffd8 0 0 00000000 // lb x26, 0x40(x0)
1 04304d83 00000174 1 1b 00000091 0 0 00000000 // lbu x27, 0x43(x0)
1 04201e03 00000178 1 1c ffff9180 0 0 00000000 // lh x28, 0x42(x0)
1 04205e83 0000017c 1 1d 00009180 0 0 00000000 // lhu x29, 0x42(x0)
1 04001f03 00000180 1 1e 000023d8 0 0 00000000 // lh x30, 0x40(x0)
1 01608863 00000184 1 00 00000000 0 1 00000194 // beq x1, x22, +16 taken
1 00208863 00000188 1 00 00000000 0 0 00000000 // beq x1, x2, +16
1 fe209ce3 0000018c 1 00 00000000 0 1 00000184 // bne x1, x2, -8 taken
1 01609863 00000190 1 00 00000000 0 0 00000000 // bne x1, x22, +16
1 00114863 00000194 1 00 00000000 0 1 000001a4 // blt x2, x1, +16 taken
1 00115863 00000198 1 00 00000000 0 0 00000000 // bge x2, x1, +16
1 fe20dce3 0000019c 1 00 00000000 0 1 00000194 // bge x1, x2, -8 taken
1 0020e863 000001a0 1 00 00000000 0 1 000001b0 // bltu x1, x2, +16 taken
1 00116863 000001a4 1 00 00000000 0 0 00000000 // bltu x2, x1, +16
1 00117863 000001a8 1 00 00000000 0 1 000001b8 // bgeu x2, x1, +16 taken
1 02000fef 000001ac 1 1f 000001b0 0 1 000001cc // jal x31, +0x20
1 008082e7 000001b0 1 05 000001b4 0 1 0000012a // jalr x5, 8(x1)
1 12345317 000001b4 1 06 123451b4 0 0 00000000 // auipc x6, 0x12345
1 05500413 000001b8 1 08 00000055 0 0 00000000 // addi x8, x0, 0x55
0 00000000 00000000 0 00 00000000 0 0 00000000 // idle
1 00140493 000001c0 1 09 00000056 0 0 00000000 // addi x9, x8, 1
1 0014848b 000001c4 1 00 00000000 1 0 00000000 // unknown opcode 0x0b on x9
0 00000000 00000000 0 00 00000000 0 0 00000000 // idle
1 00048513 000001cc 1 0a 00000056 0 0 00000000 // addi x10, x9, 0

// File: compile.f
common/rv_pkg.sv
decode/control_unit.sv
decode/imm_gen.sv
hdl/reg_file.sv
execute/exec_unit.sv
result/load_store_unit.sv
hdl/rv_exec_slice.sv
verif/tb_rv_exec_slice.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0 --Mdir obj_dir
TOP      = tb_rv_exec_slice
FILELIST = compile.f
BIN      = obj_dir/V$(TOP)
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
